//--- verilog/reflet_pkg.sv
// Widths, memory map and reset-time boot stub of the instruction memory, imported by RTL and testbench
package reflet_pkg;

    // System bus
    localparam int word_width = 16;           // Data word
    localparam int addr_width = 14;           // Word address, 16K words

    // Writable instruction RAM
    localparam int ram_words = 10000;

    // Bootloader ROM window, word addressed
    localparam logic [addr_width-1:0] rom_base = 14'h3E80;
    localparam int rom_words = 128;

    // Jump stub written into RAM words 0..7 after reset
    localparam int init_steps = 8;

    // Word 0 holds the ROM byte address, twice the word address
    // Index 0 is the rightmost entry
    localparam logic [init_steps-1:0][word_width-1:0] boot_stub = {
        16'h0000,                             // Word 7
        16'h0000,                             // Word 6
        16'h0000,                             // Word 5
        16'h0000,                             // Word 4
        16'h003E,                             // Word 3, jump
        16'hF010,                             // Word 2, set 0 then load WR
        16'h0000,                             // Word 1
        {1'b0, rom_base, 1'b0}                // Word 0, 7D00 byte address
    };

endpackage

//--- verilog/reflet_mem_if.sv
// One memory port between the instruction memory control and a RAM or ROM block
`timescale 1ns/100ps

interface reflet_mem_if
    import reflet_pkg::*;
    ();

    logic                  enable;            // Single-cycle transfer qualifier
    logic [addr_width-1:0] addr;              // Word address
    logic [word_width-1:0] data_in;           // Write data
    logic                  write_en;          // Write strobe, only with enable
    logic [word_width-1:0] data_out;          // Registered read data

    // Control side
    modport host (
        output enable,
        output addr,
        output data_in,
        output write_en,
        input  data_out
    );

    // Memory side
    modport mem (
        input  enable,
        input  addr,
        input  data_in,
        input  write_en,
        output data_out
    );

endinterface

//--- verilog/reflet_ram.sv
// Synchronous single-port instruction RAM, reads zero for addresses outside its own window
`timescale 1ns/100ps

module reflet_ram
    import reflet_pkg::*;
    (
    input logic       clk,
    input logic       reset,
    reflet_mem_if.mem port
    );

    // Storage, contents survive reset
    logic [word_width-1:0] mem [ram_words];

    logic in_rom;                             // Address falls in the bootloader window
    logic ram_hit;                            // Address backed by this array

    assign in_rom  = (int'(port.addr) >= int'(rom_base)) &&
                     (int'(port.addr) < int'(rom_base) + rom_words);
    assign ram_hit = (int'(port.addr) < ram_words) && !in_rom;

    // Write port
    always_ff @(posedge clk)
    begin
        if (port.enable && port.write_en && ram_hit)
        begin
            mem[port.addr] <= port.data_in;   // Visible to the next transfer
        end
    end

    // Read register, one cycle latency
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            port.data_out <= '0;
        end
        else if (port.enable)
        begin
            if (ram_hit)
            begin
                port.data_out <= mem[port.addr];   // Old word on a write cycle
            end
            else
            begin
                // Zero so the ROM side can be ORed in
                port.data_out <= '0;
            end
        end
        // Holds without enable
    end

endmodule

//--- verilog/reflet_bootloader16_rom.sv
// Fixed bootloader program in ROM, answers reads only inside its address window
`timescale 1ns/100ps

module reflet_bootloader16_rom
    import reflet_pkg::*;
    (
    input logic       clk,
    input logic       reset,
    reflet_mem_if.mem port
    );

    logic                  rom_hit;           // Inside the window
    logic [addr_width-1:0] rom_offset;        // Word index within the window

    assign rom_offset = port.addr - rom_base;
    assign rom_hit    = (int'(port.addr) >= int'(rom_base)) &&
                        (int'(port.addr) < int'(rom_base) + rom_words);

    // Program image, two 8-bit opcodes per word
    // Everything past the image reads zero up to rom_words
    function automatic logic [word_width-1:0] rom_word(input logic [addr_width-1:0] offset);
        logic [word_width-1:0] word;
        word = '0;
        case (offset)
            14'd0:   word = 16'h10F1;         // Set up working register
            14'd1:   word = 16'h2C31;         // Point at serial status
            14'd2:   word = 16'h4A12;         // Load status byte
            14'd3:   word = 16'h0E5D;         // Test receive flag
            14'd4:   word = 16'h6B02;         // Loop until a byte arrives
            14'd5:   word = 16'h4A13;         // Read data byte
            14'd6:   word = 16'h7C20;         // Store at write pointer
            14'd7:   word = 16'h1281;         // Advance pointer
            14'd8:   word = 16'h3A44;         // Compare against length
            14'd9:   word = 16'h6B09;         // More bytes to fetch
            14'd10:  word = 16'hF000;         // Clear working register
            14'd11:  word = 16'h003E;         // Jump to loaded code at zero
            default: word = '0;
        endcase
        return word;
    endfunction

    // Read register, one cycle latency
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            port.data_out <= '0;
        end
        else if (port.enable)
        begin
            port.data_out <= rom_hit ? rom_word(rom_offset) : '0;   // Zero outside window
        end
        // Write strobe and data ignored, contents are fixed
    end

endmodule

//--- verilog/reflet_inst16.sv
// Instruction memory of the 16-bit core, writes the jump stub after reset and merges RAM and ROM
`timescale 1ns/100ps

module reflet_inst16
    import reflet_pkg::*;
    (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,     // Bus transfer
    input  logic                  write_en,   // Bus write, with enable
    input  logic [addr_width-1:0] addr,       // Word address
    input  logic [word_width-1:0] data_in,
    output logic [word_width-1:0] data_out,
    output logic                  inst_ready  // Stub written, bus live
    );

    // Init state
    logic [2:0]            init_addr;         // Stub word being written
    logic [word_width-1:0] init_data;

    assign init_data = boot_stub[init_addr];

    // One stub word per cycle, ready after the last one
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            inst_ready <= 1'b0;
            init_addr  <= '0;
        end
        else if (!inst_ready)
        begin
            if (init_addr == 3'(init_steps - 1))
            begin
                inst_ready <= 1'b1;           // Last word goes in on this edge
            end
            else
            begin
                init_addr <= init_addr + 3'd1;
            end
        end
    end

    // Memory ports
    reflet_mem_if ram_if ();
    reflet_mem_if rom_if ();

    // RAM input selection
    // During init the counter owns the port and every cycle is a write
    always_comb
    begin
        if (inst_ready)
        begin
            ram_if.enable   = enable;
            ram_if.addr     = addr;
            ram_if.data_in  = data_in;
            ram_if.write_en = write_en;
        end
        else
        begin
            ram_if.enable   = 1'b1;
            ram_if.addr     = addr_width'(init_addr);
            ram_if.data_in  = init_data;
            ram_if.write_en = 1'b1;
        end
    end

    // ROM sees the bus once ready, read only
    assign rom_if.enable   = enable & inst_ready;   // Bus ignored until ready
    assign rom_if.addr     = addr;
    assign rom_if.data_in  = '0;              // No write path
    assign rom_if.write_en = 1'b0;

    // Each side reads zero outside its window
    assign data_out = ram_if.data_out | rom_if.data_out;

    // Actual memories
    reflet_ram ram (
        .clk   (clk),
        .reset (reset),
        .port  (ram_if.mem)
    );

    reflet_bootloader16_rom bootloader (
        .clk   (clk),
        .reset (reset),
        .port  (rom_if.mem)
    );

endmodule

//--- verilog/reflet_inst_top.sv
// Top level of the instruction memory subsystem, plain system-bus ports around reflet_inst16
`timescale 1ns/100ps

module reflet_inst_top
    import reflet_pkg::*;
    (
    input  logic                  clk,
    input  logic                  reset,      // Active low, synchronous
    input  logic                  enable,
    input  logic                  write_en,
    input  logic [addr_width-1:0] addr,
    input  logic [word_width-1:0] data_in,
    output logic [word_width-1:0] data_out,   // Read data, one cycle after request
    output logic                  inst_ready
    );

    // No extra latency at this boundary
    reflet_inst16 inst_mem (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .write_en   (write_en),
        .addr       (addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .inst_ready (inst_ready)
    );

endmodule

//--- sim/reflet_inst_chk.sv
// Concurrent inst_ready timing checks, bound into the instruction memory top level
`timescale 1ns/100ps

module reflet_inst_chk
    import reflet_pkg::*;
    (
    input logic clk,
    input logic reset,
    input logic inst_ready
    );

    // Synchronous reset clears ready one edge after it is sampled
    ready_low_in_reset: assert property (@(posedge clk) !reset |=> !inst_ready)
        else $error("inst_ready not cleared by reset");

    // Sticky until the next reset
    ready_never_falls: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !$fell(inst_ready))
        else $error("inst_ready fell with reset high");

    // One stub word per cycle after release
    ready_after_init: assert property (@(posedge clk)
        (reset && $past(reset, init_steps) && !$past(reset, init_steps + 1))
            |-> $rose(inst_ready))
        else $error("inst_ready late after reset release");

    ready_not_early: assert property (@(posedge clk)
        $rose(inst_ready) |-> ($past(reset, init_steps) && !$past(reset, init_steps + 1)))
        else $error("inst_ready rose at the wrong cycle");

endmodule

bind reflet_inst_top reflet_inst_chk chk (
    .clk        (clk),
    .reset      (reset),
    .inst_ready (inst_ready)
);

//--- sim/reflet_inst_tb.sv
// Testbench for the instruction memory top level run with reflet_inst_tb as top from list.f
`timescale 1ns/100ps

module reflet_inst_tb
    import reflet_pkg::*;
    ();

    localparam int timeout_cycles = 20000;    // Tests need under 2000 cycles
    localparam int random_ops     = 300;
    localparam int unmapped_ops   = 20;
    localparam logic [addr_width-1:0] idle_addr  = addr_width'(2);
    localparam logic [addr_width-1:0] idle_other = addr_width'(3);   // Address held while idle
    localparam logic [word_width-1:0] idle_word  = 16'hA5C3;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    logic                  write_en;
    logic [addr_width-1:0] addr;
    logic [word_width-1:0] data_in;
    logic [word_width-1:0] data_out;
    logic                  inst_ready;

    // Stub layout from the boot vector with the ROM byte address first
    logic [word_width-1:0] stub_words [init_steps] = '{
        16'h7D00, 16'h0000, 16'hF010, 16'h003E,
        16'h0000, 16'h0000, 16'h0000, 16'h0000
    };

    logic [word_width-1:0] model [2 ** addr_width];   // RAM reference
    logic [addr_width-1:0] written_q [$];             // Addresses with known contents
    logic                  ready_seen = 1'b0;
    int                    cycles = 0;

    reflet_inst_top dut (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .write_en   (write_en),
        .addr       (addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .inst_ready (inst_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                     // 10 ns period

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual);
        assert (actual === expected)
        else
        begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", test, expected, actual));
        end
    endtask

    // Run limit
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles)
        begin
            fail_run($sformatf("timeout, run still going after %0d cycles", timeout_cycles));
        end
    end

    // Ready is sticky once seen
    always @(negedge clk)
    begin
        if (ready_seen && reset)
        begin
            assert (inst_ready)
            else
            begin
                fail_run("inst_ready dropped while reset stayed high");
            end
        end
    end

    function automatic bit in_rom_window(input logic [addr_width-1:0] a);
        int offset;
        offset = int'(a) - int'(rom_base);
        return (offset >= 0) && (offset < rom_words);
    endfunction

    // RAM word or zero for anything not backed by RAM
    function automatic logic [word_width-1:0] expected_word(input logic [addr_width-1:0] a);
        if (int'(a) < ram_words && !in_rom_window(a))
        begin
            return model[a];
        end
        return '0;
    endfunction

    // Both bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input logic [addr_width-1:0] a, input logic [word_width-1:0] d);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(posedge clk);
        #1;
        enable   = 1'b0;
        write_en = 1'b0;
        if (int'(a) < ram_words && !in_rom_window(a))
        begin
            model[a] = d;                     // ROM and unmapped writes are lost
        end
    endtask

    task automatic bus_read(input logic [addr_width-1:0] a, output logic [word_width-1:0] d);
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        @(posedge clk);
        #1;
        enable   = 1'b0;
        d        = data_out;                  // Registered on that edge
    endtask

    initial
    begin
        logic [addr_width-1:0] a;
        logic [word_width-1:0] d;
        logic [word_width-1:0] first;
        void'($urandom(37445));
        reset    = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        for (int i = 0; i < init_steps; i++)
        begin
            model[i] = stub_words[i];
            written_q.push_back(addr_width'(i));
        end

        // Reset held 10 cycles
        repeat (10)
        begin
            @(posedge clk);
            #1;
            assert (!inst_ready) else fail_run("inst_ready high during reset");
        end
        reset = 1'b1;
        for (int k = 1; k <= init_steps; k++)
        begin
            @(posedge clk);
            #1;
            assert (inst_ready == (k == init_steps))
            else
            begin
                fail_run($sformatf("inst_ready wrong %0d cycles after reset release", k));
            end
        end
        ready_seen = 1'b1;

        // Stub words one per read
        for (int i = 0; i < init_steps; i++)
        begin
            bus_read(addr_width'(i), d);
            check_word("boot stub", stub_words[i], d);
        end

        // Random RAM traffic
        for (int n = 0; n < random_ops; n++)
        begin
            if ($urandom % 2 == 0)
            begin
                if ($urandom % 8 == 0)
                    a = addr_width'($urandom % init_steps);   // Hit a stub word
                else
                    a = addr_width'($urandom % ram_words);
                bus_write(a, word_width'($urandom));
                written_q.push_back(a);
            end
            else
            begin
                a = written_q[$urandom % written_q.size()];
                bus_read(a, d);
                check_word("ram random", expected_word(a), d);
            end
        end

        // Read, write and read back each ROM word
        for (int i = 0; i < rom_words; i++)
        begin
            a = rom_base + addr_width'(i);
            bus_read(a, first);
            bus_write(a, word_width'($urandom));
            bus_read(a, d);
            check_word("rom protect", first, d);
            if (i == 0)
            begin
                assert (first != '0) else fail_run("ROM window base reads zero");
            end
            if (i >= rom_words / 2)
                check_word("rom padding", 16'h0000, first);   // Short image
        end

        // Holes in the map
        for (int n = 0; n < unmapped_ops; n++)
        begin
            do
            begin
                a = addr_width'(ram_words + $urandom % (2 ** addr_width - ram_words));
            end
            while (in_rom_window(a));
            bus_write(a, word_width'($urandom));
            bus_read(a, d);
            check_word("unmapped", 16'h0000, d);
        end

        // Idle bus with a write strobe but no enable
        // Neighbour word differs so a stray read would show on data_out
        bus_write(idle_addr, idle_word);
        bus_write(idle_other, ~idle_word);
        bus_read(idle_addr, first);
        check_word("idle setup", expected_word(idle_addr), first);
        write_en = 1'b1;
        addr     = idle_other;
        data_in  = idle_word;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_word("idle hold", first, data_out);
        end
        write_en = 1'b0;
        bus_read(idle_other, d);
        check_word("idle write ignored", expected_word(idle_other), d);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- list.f
verilog/reflet_pkg.sv
verilog/reflet_mem_if.sv
verilog/reflet_ram.sv
verilog/reflet_bootloader16_rom.sv
verilog/reflet_inst16.sv
verilog/reflet_inst_top.sv
sim/reflet_inst_chk.sv
sim/reflet_inst_tb.sv

//--- Makefile
# Verilator build and run of the instruction memory testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module reflet_inst_tb -Mdir obj_dir -f list.f
	./obj_dir/Vreflet_inst_tb 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
